// ==== run_sim.sh ====
#!/bin/bash
# Build the cartridge testbench with Verilator, run it and look for the pass line

verilator --binary --timing --assert -Wno-fatal -f sources.f \
	--top-module cart_tb -o cart_sim \
	&& ./obj_dir/cart_sim | tee /dev/stderr | grep -F '*** TEST PASSED ***' > /dev/null \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// ==== sources.f ====
+incdir+tb
verilog/cart_pkg.sv
verilog/rom_store.sv
verilog/rom_loader.sv
verilog/rom_arbiter.sv
verilog/header_detect.sv
verilog/save_ram.sv
verilog/md_mapper.sv
verilog/cart_top.sv
tb/cart_tb.sv

// ==== tb/cart_tb_checks.svh ====
// Testbench bus and check helpers
`ifndef CART_TB_CHECKS_SVH
`define CART_TB_CHECKS_SVH

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// One register step per bit taken
task automatic draw_word(output word_t w);
	w = '0;
	for (int i = 0; i < 16; i++) begin
		lfsr_state = lfsr_step(lfsr_state);
		w = {w[14:0], lfsr_state[0]};
	end
endtask

// ============================================================
// Typed compares
// ============================================================

task automatic check_word(input string what, input word_t got, input word_t exp);
	if (got !== exp) begin
		$display("ERR %0t ns: %s read %h, expected %h", $time, what, got, exp);
		stop_with_failure();
	end
endtask

task automatic check_flag(input string what, input logic got, input logic exp);
	if (got !== exp) begin
		$display("ERR %0t ns: %s is %b, expected %b", $time, what, got, exp);
		stop_with_failure();
	end
endtask

task automatic wait_dtack(input logic level);
	int n;
	n = 0;
	while (cart_dtack !== level) begin
		@(negedge clk);
		n++;
		if (n > READ_ALLOW) begin
			$display("cart_dtack did not reach %b within %0d cycles", level, READ_ALLOW);
			stop_with_failure();
		end
	end
endtask

// ============================================================
// Bus tasks, entered and left on a falling edge
// ============================================================

task automatic download_word(input logic [24:0] addr, input word_t data);
	int n;
	n = 0;
	@(negedge clk);
	cart_dl_addr = addr;
	cart_dl_data = data;
	cart_dl_wr   = 1'b1;
	@(negedge clk);
	cart_dl_wr = 1'b0;
	check_flag("cart_dl_wait", cart_dl_wait, 1'b1);
	while (cart_dl_wait) begin
		@(negedge clk);
		n++;
		if (n > READ_ALLOW) begin
			$display("cart_dl_wait stayed high for more than %0d cycles", READ_ALLOW);
			stop_with_failure();
		end
	end
endtask

task automatic console_read(input logic [23:0] addr, input word_t exp);
	@(negedge clk);
	cart_addr = addr[23:1];
	cart_cs   = 1'b1;
	cart_oe   = 1'b1;
	@(negedge clk);
	wait_dtack(1'b1);
	check_word("cart_data", cart_data, exp);
	check_flag("cart_data_en", cart_data_en, 1'b1);
	cart_oe = 1'b0;
	@(negedge clk);
	wait_dtack(1'b0);
	cart_cs = 1'b0;
endtask

task automatic console_write(input logic [23:0] addr, input word_t data);
	@(negedge clk);
	cart_addr    = addr[23:1];
	cart_data_wr = data;
	cart_cs      = 1'b1;
	cart_lwr     = 1'b1;
	@(negedge clk);
	check_flag("save_change", save_change, 1'b1);
	cart_lwr = 1'b0;
	cart_cs  = 1'b0;
endtask

task automatic register_write(input logic [23:0] addr, input word_t data);
	@(negedge clk);
	cart_addr    = addr[23:1];
	cart_data_wr = data;
	cart_time    = 1'b1;
	cart_lwr     = 1'b1;
	@(negedge clk);
	cart_time = 1'b0;
	cart_lwr  = 1'b0;
endtask

task automatic save_read(input logic [SRAM_AW-2:0] addr, input word_t exp);
	@(negedge clk);
	save_addr = addr;
	@(negedge clk);
	check_word("save_do", save_do, exp);
endtask

task automatic save_write(input logic [SRAM_AW-2:0] addr, input word_t data);
	@(negedge clk);
	save_addr = addr;
	save_di   = data;
	save_wr   = 1'b1;
	@(negedge clk);
	save_wr = 1'b0;
endtask

`endif

// ==== tb/cart_tb.sv ====
// Cartridge unit testbench
`timescale 1ns/100ps
`default_nettype none

module cart_tb import cart_pkg::*; ();

	localparam int ROM_AW      = 12;
	localparam int WINDOW_AW   = 10;
	localparam int SRAM_AW     = 10;
	localparam int IMAGE_WORDS = 1536;
	localparam int READ_ALLOW  = 8;

	localparam int OP_DL_BEGIN = 0;
	localparam int OP_DL_WORD  = 1;
	localparam int OP_DL_END   = 2;
	localparam int OP_QUIRK    = 3;
	localparam int OP_READ     = 4;
	localparam int OP_WRITE    = 5;
	localparam int OP_REG      = 6;
	localparam int OP_SAVE_RD  = 7;
	localparam int OP_SAVE_WR  = 8;

	logic               clk;
	logic               reset;
	logic               cart_dl;
	logic [24:0]        cart_dl_addr;
	word_t              cart_dl_data;
	logic               cart_dl_wr;
	logic               cart_dl_wait;
	cart_addr_t         cart_addr;
	word_t              cart_data_wr;
	logic               cart_cs;
	logic               cart_oe;
	logic               cart_lwr;
	logic               cart_time;
	word_t              cart_data;
	logic               cart_data_en;
	logic               cart_dtack;
	logic [SRAM_AW-2:0] save_addr;
	word_t              save_di;
	logic               save_wr;
	word_t              save_do;
	logic               save_change;
	logic               ym2612_quirk;

	// Reference model of the cartridge state
	logic [31:0]       lfsr_state = 32'h9d2c15b0;
	word_t             image [IMAGE_WORDS];
	bank_t             bank_m [NUM_BANKS];
	logic              bank_use_m;
	logic [ROM_AW-1:0] mask_m;
	word_t             save_m [2**(SRAM_AW-1)];

	// Stimulus table
	int          op_q[$];
	logic [24:0] addr_q[$];
	word_t       data_q[$];
	word_t       exp_q[$];

	int cycles = 0;
	int cycle_limit = 1000;

	cart_top #(
		.ROM_AW   (ROM_AW),
		.WINDOW_AW(WINDOW_AW),
		.SRAM_AW  (SRAM_AW)
	) dut_i (.*);

	task automatic stop_with_failure();
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	`include "cart_tb_checks.svh"

	// ============================================================
	// Table building
	// ============================================================

	function automatic void add_op(input int op, input logic [24:0] a, input word_t d,
		input word_t e);
		op_q.push_back(op);
		addr_q.push_back(a);
		data_q.push_back(d);
		exp_q.push_back(e);
	endfunction

	// Bank replaces the top window bits, then the size mask applies
	function automatic int rom_index(input logic [23:0] a);
		logic [12:0] w;
		if (bank_use_m)
			w = {bank_m[a[10:8]], a[7:1]};
		else
			w = a[13:1];
		return int'(w[ROM_AW-1:0] & mask_m);
	endfunction

	function automatic void add_rom_read(input logic [23:0] a);
		add_op(OP_READ, {1'b0, a}, '0, image[rom_index(a)]);
	endfunction

	function automatic void add_sram_write(input logic [23:0] a, input byte_t b);
		logic [SRAM_AW-1:0] s;
		s = a[SRAM_AW:1];
		if (s[0])
			save_m[s[SRAM_AW-1:1]][15:8] = b;
		else
			save_m[s[SRAM_AW-1:1]][7:0] = b;
		add_op(OP_WRITE, {1'b0, a}, {8'h00, b}, '0);
	endfunction

	function automatic void add_sram_read(input logic [23:0] a);
		logic [SRAM_AW-1:0] s;
		word_t              w;
		byte_t              b;
		s = a[SRAM_AW:1];
		w = save_m[s[SRAM_AW-1:1]];
		b = s[0] ? w[15:8] : w[7:0];
		add_op(OP_READ, {1'b0, a}, '0, {b, b});
	endfunction

	task automatic add_download(input logic [63:0] serial);
		add_op(OP_DL_BEGIN, '0, '0, '0);
		for (int i = 0; i < IMAGE_WORDS; i++)
			draw_word(image[i]);
		// First character of each pair in the low byte
		for (int j = 0; j < 4; j++)
			image[HDR_SERIAL_ADDR + j] = {serial[55-16*j -: 8], serial[63-16*j -: 8]};
		mask_m = '0;
		for (int i = 0; i < IMAGE_WORDS; i++) begin
			add_op(OP_DL_WORD, 25'(i), image[i], '0);
			mask_m = mask_m | ROM_AW'(i);
		end
		for (int i = 0; i < 2**(SRAM_AW-1); i++)
			save_m[i] = (serial == " GM 0000") ? 16'h0000 : 16'hFFFF;
		add_op(OP_DL_END, '0, '0, '0);
	endtask

	task automatic build_table();
		for (int i = 0; i < NUM_BANKS; i++)
			bank_m[i] = bank_t'(i);
		bank_use_m = 1'b0;
		// Hellfire image, direct and mirrored reads
		add_download("T-35036 ");
		add_op(OP_QUIRK, '0, '0, 16'h0001);
		for (int k = 0; k < 12; k++)
			add_rom_read(24'(2 * k * 127));
		add_rom_read(24'h000308);
		for (int k = 0; k < 8; k++) begin
			add_rom_read(24'(2 * (2048 + k * 131)));
			add_rom_read(24'(2 * (3072 + k * 37)));
		end
		// Banks 1 and 2
		add_op(OP_REG, 25'hA130F3, 16'h0005, '0);
		add_op(OP_REG, 25'hA130F5, 16'h0009, '0);
		bank_m[1] = 6'd5;
		bank_m[2] = 6'd9;
		bank_use_m = 1'b1;
		add_rom_read(24'h000010);
		add_rom_read(24'h000100);
		add_rom_read(24'h00017E);
		add_rom_read(24'h000204);
		add_rom_read(24'h0002FE);
		add_rom_read(24'h000342);
		add_rom_read(24'h040122);
		// Save RAM from both ports
		add_sram_write(24'h200043, 8'h5A);
		add_sram_write(24'h200040, 8'hC3);
		add_sram_read(24'h200043);
		add_sram_read(24'h200040);
		add_op(OP_SAVE_RD, 25'h10, '0, save_m[9'h10]);
		add_op(OP_SAVE_WR, 25'h33, 16'h1234, '0);
		save_m[9'h33] = 16'h1234;
		add_op(OP_SAVE_RD, 25'h33, '0, 16'h1234);
		add_sram_read(24'h2000CC);
		add_sram_read(24'h2000CE);
		// Puggsy has no save RAM
		add_download("T-113016");
		add_op(OP_QUIRK, '0, '0, 16'h0000);
		add_rom_read(24'h200040);
		add_rom_read(24'h200104);
		add_op(OP_SAVE_RD, 25'h10, '0, save_m[9'h10]);
		// Zero cleared save RAM
		add_download(" GM 0000");
		add_op(OP_QUIRK, '0, '0, 16'h0000);
		add_op(OP_SAVE_RD, 25'h10, '0, save_m[9'h10]);
		add_op(OP_SAVE_RD, 25'h1FF, '0, save_m[9'h1FF]);
		add_rom_read(24'h000202);
	endtask

	// ============================================================
	// Clock, reset, apply loop
	// ============================================================

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > cycle_limit) begin
			$display("Timeout: the run took more than %0d cycles", cycle_limit);
			stop_with_failure();
		end
	end

	initial begin
		reset        = 1'b1;
		cart_dl      = 1'b0;
		cart_dl_addr = '0;
		cart_dl_data = '0;
		cart_dl_wr   = 1'b0;
		cart_addr    = '0;
		cart_data_wr = '0;
		cart_cs      = 1'b0;
		cart_oe      = 1'b0;
		cart_lwr     = 1'b0;
		cart_time    = 1'b0;
		save_addr    = '0;
		save_di      = '0;
		save_wr      = 1'b0;
		build_table();
		cycle_limit = 40 * op_q.size() * READ_ALLOW;
		repeat (5) @(negedge clk);
		reset = 1'b0;
		for (int i = 0; i < op_q.size(); i++) begin
			case (op_q[i])
				OP_DL_BEGIN: begin
					@(negedge clk);
					cart_dl = 1'b1;
					@(negedge clk);
				end
				OP_DL_WORD: download_word(addr_q[i], data_q[i]);
				OP_DL_END: begin
					@(negedge clk);
					cart_dl = 1'b0;
					repeat (2) @(negedge clk);
				end
				OP_QUIRK: check_flag("ym2612_quirk", ym2612_quirk, exp_q[i][0]);
				OP_READ: console_read(addr_q[i][23:0], exp_q[i]);
				OP_WRITE: console_write(addr_q[i][23:0], data_q[i]);
				OP_REG: register_write(addr_q[i][23:0], data_q[i]);
				OP_SAVE_RD: save_read(addr_q[i][SRAM_AW-2:0], exp_q[i]);
				OP_SAVE_WR: save_write(addr_q[i][SRAM_AW-2:0], data_q[i]);
				default: begin
					$display("Unknown operation in the stimulus table at entry %0d", i);
					stop_with_failure();
				end
			endcase
		end
		repeat (2) @(negedge clk);
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/cart_pkg.sv ====
// Cartridge shared definitions
`default_nettype none

package cart_pkg;

	// ==========================================================
	// Bus and memory types
	// ==========================================================

	// 68000 data bus word, also one ROM store word
	typedef logic [15:0] word_t;

	// One save RAM byte
	typedef logic [7:0] byte_t;

	// 68000 word address, A23..A1
	typedef logic [23:1] cart_addr_t;

	// SSF2 bank register
	typedef logic [5:0] bank_t;

	// ==========================================================
	// Memory map
	// ==========================================================

	// A23..A21 of the 0x200000 save RAM region
	localparam logic [2:0] SRAM_REGION = 3'd1;

	// Upper pages of the region never fall back to save RAM by size
	localparam logic [1:0] TOP_PAGES = 2'b11;

	localparam int NUM_BANKS = 8;

	// Header offsets, counted in download words
	localparam logic [24:0] HDR_SERIAL_ADDR = 25'h184;
	localparam logic [24:0] HDR_DECIDE_ADDR = 25'h190;

endpackage

`default_nettype wire

// ==== verilog/cart_top.sv ====
// Mega Drive cartridge top level
`timescale 1ns/100ps
`default_nettype none

module cart_top import cart_pkg::*; #(
	parameter int ROM_AW    = 22,
	parameter int WINDOW_AW = 21,
	parameter int SRAM_AW   = 16
) (
	input  wire               clk,
	input  wire               reset,

	input  wire               cart_dl,
	input  wire [24:0]        cart_dl_addr,
	input  wire word_t        cart_dl_data,
	input  wire               cart_dl_wr,
	output logic              cart_dl_wait,

	input  wire cart_addr_t   cart_addr,
	input  wire word_t        cart_data_wr,
	input  wire               cart_cs,
	input  wire               cart_oe,
	input  wire               cart_lwr,
	input  wire               cart_time,
	output word_t             cart_data,
	output logic              cart_data_en,
	output logic              cart_dtack,

	input  wire [SRAM_AW-2:0] save_addr,
	input  wire word_t        save_di,
	input  wire               save_wr,
	output word_t             save_do,
	output logic              save_change,

	output logic              ym2612_quirk
);

	// Loader and mapper clients of the ROM store
	logic [ROM_AW-1:0] ld_addr;
	word_t             ld_data;
	logic              ld_req;
	logic              ld_ack;
	logic [ROM_AW-1:0] rd_addr;
	logic              rd_req;
	logic              rd_ack;
	word_t             rd_data;

	logic [ROM_AW-1:0] mem_addr;
	word_t             mem_wdata;
	logic              mem_we;
	word_t             mem_rdata;

	logic [ROM_AW-1:0] rom_mask;
	logic [ROM_AW:0]   rom_size;

	logic              noram;
	logic              sram00;

	// Console side of the save RAM
	logic [SRAM_AW-1:0] sram_addr;
	byte_t              sram_wdata;
	logic               sram_we;
	byte_t              sram_q;

	rom_loader #(.ROM_AW(ROM_AW)) loader_i (.*);

	rom_arbiter #(.ROM_AW(ROM_AW)) arbiter_i (.*);

	rom_store #(.ROM_AW(ROM_AW)) store_i (.*);

	md_mapper #(
		.ROM_AW   (ROM_AW),
		.WINDOW_AW(WINDOW_AW),
		.SRAM_AW  (SRAM_AW)
	) mapper_i (.*);

	header_detect header_i (.*, .fm_busy(ym2612_quirk));

	save_ram #(.SRAM_AW(SRAM_AW)) save_ram_i (.*);

endmodule

`default_nettype wire

// ==== verilog/header_detect.sv ====
// ROM header quirk detection
`timescale 1ns/100ps
`default_nettype none

module header_detect import cart_pkg::*; (
	input  wire        clk,
	input  wire        cart_dl,
	input  wire [24:0] cart_dl_addr,
	input  wire word_t cart_dl_data,
	input  wire        cart_dl_wr,
	output logic       noram,
	output logic       sram00,
	output logic       fm_busy
);

	// Serial numbers of the special carts
	localparam logic [63:0] SER_PUGGSY   = "T-113016";
	localparam logic [63:0] SER_SONIC_RM = " GM 0000";
	localparam logic [63:0] SER_HELL_US  = "T-35036 ";
	localparam logic [63:0] SER_HELL_JP  = "T-25073 ";
	localparam logic [63:0] SER_HELL_EU  = "MK-1137-";
	localparam logic [63:0] SER_TWINHAWK = "G-4034  ";

	logic [63:0] serial;
	logic        dl_d;
	logic        dl_strobe;
	logic        decide;
	logic [24:0] ser_off;
	word_t       swapped;

	// First character sits in the low byte of a download word
	assign swapped   = {cart_dl_data[7:0], cart_dl_data[15:8]};
	assign ser_off   = cart_dl_addr - HDR_SERIAL_ADDR;
	assign dl_strobe = cart_dl && cart_dl_wr;
	assign decide    = dl_strobe && (cart_dl_addr == HDR_DECIDE_ADDR);

	always_ff @(posedge clk) begin
		if (dl_strobe && ser_off < 25'd4)
			serial[16*(3 - ser_off[1:0]) +: 16] <= swapped;
	end

	always_ff @(posedge clk) begin
		dl_d <= cart_dl;
		if (cart_dl && !dl_d) begin
			noram   <= 1'b0;
			sram00  <= 1'b0;
			fm_busy <= 1'b0;
		end else if (decide) begin
			noram   <= serial == SER_PUGGSY;
			sram00  <= serial == SER_SONIC_RM;
			fm_busy <= serial == SER_HELL_US || serial == SER_HELL_JP ||
				serial == SER_HELL_EU || serial == SER_TWINHAWK;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/md_mapper.sv ====
// Mega Drive bank mapper and bus interface
`timescale 1ns/100ps
`default_nettype none

module md_mapper import cart_pkg::*; #(
	parameter int ROM_AW    = 22,
	parameter int WINDOW_AW = 21,
	parameter int SRAM_AW   = 16
) (
	input  wire                clk,
	input  wire                reset,
	input  wire cart_addr_t    cart_addr,
	input  wire word_t         cart_data_wr,
	input  wire                cart_cs,
	input  wire                cart_oe,
	input  wire                cart_lwr,
	input  wire                cart_time,
	output word_t              cart_data,
	output logic               cart_data_en,
	output logic               cart_dtack,
	input  wire [ROM_AW-1:0]   rom_mask,
	input  wire [ROM_AW:0]     rom_size,
	input  wire                noram,
	output logic [ROM_AW-1:0]  rd_addr,
	output logic               rd_req,
	input  wire                rd_ack,
	input  wire word_t         rd_data,
	output logic [SRAM_AW-1:0] sram_addr,
	output byte_t              sram_wdata,
	output logic               sram_we,
	input  wire byte_t         sram_q
);

	localparam int PAGE_AW = WINDOW_AW - 3;

	bank_t              bank [NUM_BANKS];
	logic               bank_sram;
	logic               bank_use;
	logic               rom_big;
	logic [2:0]         bank_sel;
	logic [PAGE_AW+5:0] banked;
	cart_addr_t         trans_addr;
	logic               sram_cs;
	logic               rom_cs;
	logic               oe_d;
	logic               rd_pend;
	logic               rd_start;
	logic               rd_done;
	logic [1:0]         ram_rd;

	// ==========================================================
	// Bank registers in the time window
	// ==========================================================

	assign rom_big = |(rom_mask >> WINDOW_AW);

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_BANKS; i++) begin
				bank[i] <= bank_t'(i);
			end
			bank_sram <= 1'b0;
			bank_use  <= 1'b0;
		end else if (cart_lwr && cart_time) begin
			if (!rom_big) begin
				// Small ROM has no banks, any write enables the save RAM
				bank_sram <= 1'b1;
			end else if (cart_addr[3:1] == 3'd0) begin
				bank_sram <= cart_data_wr[0];
			end else begin
				bank[cart_addr[3:1]] <= cart_data_wr[5:0];
				bank_use             <= 1'b1;
			end
		end
	end

	// Bank replaces the top three window bits
	assign bank_sel   = cart_addr[WINDOW_AW -: 3];
	assign banked     = {bank[bank_sel], cart_addr[PAGE_AW:1]};
	assign trans_addr = bank_use ? cart_addr_t'(banked) : cart_addr;

	// ==========================================================
	// Chip selects
	// ==========================================================

	assign sram_cs = (cart_addr[23:21] == SRAM_REGION) && !noram &&
		(bank_sram || (cart_addr >= cart_addr_t'(rom_size) &&
		cart_addr[WINDOW_AW-1 -: 2] != TOP_PAGES));
	assign rom_cs       = cart_cs && !sram_cs;
	assign cart_data_en = cart_oe && (cart_cs || sram_cs);

	// Odd bytes of the region only
	assign sram_addr  = cart_addr[SRAM_AW:1];
	assign sram_wdata = cart_data_wr[7:0];
	assign sram_we    = sram_cs && cart_lwr;

	// ==========================================================
	// Read cycle
	// ==========================================================

	assign rd_start = cart_oe && !oe_d && rom_cs && !rd_pend;
	assign rd_done  = rd_pend && (rd_req == rd_ack);

	always_ff @(posedge clk) begin
		if (reset) begin
			oe_d       <= 1'b0;
			rd_req     <= 1'b0;
			rd_pend    <= 1'b0;
			ram_rd     <= '0;
			cart_dtack <= 1'b0;
		end else begin
			oe_d   <= cart_oe;
			ram_rd <= {ram_rd[0], cart_oe && !oe_d && sram_cs};
			if (!cart_oe)
				cart_dtack <= 1'b0;
			if (rd_start) begin
				rd_req  <= ~rd_req;
				rd_pend <= 1'b1;
			end else if (rd_done) begin
				rd_pend    <= 1'b0;
				cart_dtack <= cart_oe;
			end
			if (ram_rd[1])
				cart_dtack <= cart_oe;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_start)
			rd_addr <= trans_addr[ROM_AW:1] & rom_mask;
		if (rd_done)
			cart_data <= rd_data;
		else if (ram_rd[1])
			cart_data <= {sram_q, sram_q};
	end

	a_ack_pending: assert property (@(posedge clk) disable iff (reset)
		(rd_ack != $past(rd_ack)) |-> $past(rd_pend))
		else $error("ROM acknowledge without a pending read");

endmodule

`default_nettype wire

// ==== verilog/rom_arbiter.sv ====
// ROM store arbiter
`timescale 1ns/100ps
`default_nettype none

module rom_arbiter import cart_pkg::*; #(
	parameter int ROM_AW = 22
) (
	input  wire               clk,
	input  wire               reset,
	input  wire [ROM_AW-1:0]  ld_addr,
	input  wire word_t        ld_data,
	input  wire               ld_req,
	output logic              ld_ack,
	input  wire [ROM_AW-1:0]  rd_addr,
	input  wire               rd_req,
	output logic              rd_ack,
	output word_t             rd_data,
	output logic [ROM_AW-1:0] mem_addr,
	output word_t             mem_wdata,
	output logic              mem_we,
	input  wire word_t        mem_rdata
);

	logic ld_pend;
	logic rd_pend;
	logic grant_ld;
	logic grant_rd;
	logic busy;
	logic sel_rd;

	assign ld_pend = ld_req != ld_ack;
	assign rd_pend = rd_req != rd_ack;

	// Loader wins, one access in flight
	assign grant_ld = !busy && ld_pend;
	assign grant_rd = !busy && !ld_pend && rd_pend;

	assign mem_addr  = grant_ld ? ld_addr : rd_addr;
	assign mem_wdata = ld_data;
	assign mem_we    = grant_ld;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy   <= 1'b0;
			sel_rd <= 1'b0;
			ld_ack <= 1'b0;
			rd_ack <= 1'b0;
		end else if (busy) begin
			busy <= 1'b0;
			if (sel_rd)
				rd_ack <= ~rd_ack;
			else
				ld_ack <= ~ld_ack;
		end else if (grant_ld || grant_rd) begin
			busy   <= 1'b1;
			sel_rd <= grant_rd;
		end
	end

	// Store output is one cycle behind the granted address
	always_ff @(posedge clk) begin
		if (busy && sel_rd)
			rd_data <= mem_rdata;
	end

	// A client holds its request until the acknowledge catches up
	a_req_held: assert property (@(posedge clk) disable iff (reset)
		!(($past(ld_pend) && ld_req != $past(ld_req)) ||
		($past(rd_pend) && rd_req != $past(rd_req))))
		else $error("request toggled while still outstanding");

endmodule

`default_nettype wire

// ==== verilog/rom_loader.sv ====
// ROM download loader
`timescale 1ns/100ps
`default_nettype none

module rom_loader import cart_pkg::*; #(
	parameter int ROM_AW = 22
) (
	input  wire               clk,
	input  wire               reset,
	input  wire               cart_dl,
	input  wire word_t        cart_dl_data,
	input  wire               cart_dl_wr,
	output logic              cart_dl_wait,
	output logic [ROM_AW-1:0] ld_addr,
	output word_t             ld_data,
	output logic              ld_req,
	input  wire               ld_ack,
	output logic [ROM_AW-1:0] rom_mask,
	output logic [ROM_AW:0]   rom_size
);

	logic              dl_d;
	logic              dl_rise;
	logic              dl_strobe;
	logic [ROM_AW:0]   size_base;
	logic [ROM_AW-1:0] mask_base;

	assign dl_rise   = cart_dl && !dl_d;
	assign dl_strobe = cart_dl && cart_dl_wr;

	// A new download starts from an empty image
	assign size_base = dl_rise ? '0 : rom_size;
	assign mask_base = dl_rise ? '0 : rom_mask;

	always_ff @(posedge clk) begin
		if (reset) begin
			dl_d         <= 1'b0;
			cart_dl_wait <= 1'b0;
			ld_req       <= 1'b0;
			rom_size     <= '0;
			rom_mask     <= '0;
		end else begin
			dl_d     <= cart_dl;
			rom_size <= size_base;
			rom_mask <= mask_base;
			if (dl_strobe) begin
				cart_dl_wait <= 1'b1;
				ld_req       <= ~ld_req;
				// Mask grows to the next power of two
				rom_mask     <= mask_base | size_base[ROM_AW-1:0];
				rom_size     <= size_base + 1'b1;
			end else if (ld_req == ld_ack) begin
				cart_dl_wait <= 1'b0;
			end
		end
	end

	// Word goes to the next free address
	always_ff @(posedge clk) begin
		if (dl_strobe) begin
			ld_addr <= size_base[ROM_AW-1:0];
			ld_data <= cart_dl_data;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/rom_store.sv ====
// Cartridge ROM store
`timescale 1ns/100ps
`default_nettype none

module rom_store import cart_pkg::*; #(
	parameter int ROM_AW = 22
) (
	input  wire              clk,
	input  wire [ROM_AW-1:0] mem_addr,
	input  wire word_t       mem_wdata,
	input  wire              mem_we,
	output word_t            mem_rdata
);

	// ==========================================================
	// Single-port word memory
	// ==========================================================

	word_t mem [2**ROM_AW];

	// Read returns the old word on a write cycle
	always_ff @(posedge clk) begin
		if (mem_we)
			mem[mem_addr] <= mem_wdata;
		mem_rdata <= mem[mem_addr];
	end

endmodule

`default_nettype wire

// ==== verilog/save_ram.sv ====
// Battery backed save RAM
`timescale 1ns/100ps
`default_nettype none

module save_ram import cart_pkg::*; #(
	parameter int SRAM_AW = 16
) (
	input  wire               clk,
	input  wire               cart_dl,
	input  wire               sram00,
	input  wire [SRAM_AW-1:0] sram_addr,
	input  wire byte_t        sram_wdata,
	input  wire               sram_we,
	output byte_t             sram_q,
	input  wire [SRAM_AW-2:0] save_addr,
	input  wire word_t        save_di,
	input  wire               save_wr,
	output word_t             save_do,
	output logic              save_change
);

	byte_t              ram_lo [2**(SRAM_AW-1)];
	byte_t              ram_hi [2**(SRAM_AW-1)];
	logic [SRAM_AW-2:0] sweep;
	logic [SRAM_AW-2:0] a_word;
	logic [SRAM_AW-2:0] b_addr;
	word_t              b_data;
	logic               b_we;
	logic               a_hi;
	byte_t              a_lo_q;
	byte_t              a_hi_q;

	// Even console byte is the low half of the host word
	assign a_word = sram_addr[SRAM_AW-1:1];

	// Download sweep owns the host port
	assign b_addr = cart_dl ? sweep : save_addr;
	assign b_data = cart_dl ? (sram00 ? 16'h0000 : 16'hFFFF) : save_di;
	assign b_we   = cart_dl || save_wr;

	always_ff @(posedge clk) begin
		sweep <= cart_dl ? sweep + 1'b1 : '0;
	end

	always_ff @(posedge clk) begin
		if (sram_we && !sram_addr[0])
			ram_lo[a_word] <= sram_wdata;
		if (sram_we && sram_addr[0])
			ram_hi[a_word] <= sram_wdata;
		if (b_we) begin
			ram_lo[b_addr] <= b_data[7:0];
			ram_hi[b_addr] <= b_data[15:8];
		end
		a_lo_q  <= ram_lo[a_word];
		a_hi_q  <= ram_hi[a_word];
		a_hi    <= sram_addr[0];
		save_do <= {ram_hi[b_addr], ram_lo[b_addr]};
	end

	assign sram_q      = a_hi ? a_hi_q : a_lo_q;
	assign save_change = sram_we;

endmodule

`default_nettype wire
